/* tb/hier_input.txt */
# name op i_addr d_addr wdata exp_instr exp_data, all values hex
# op 0 instruction read, 1 data read, 2 data write, 3 instruction and data read together
imiss_8010      0 8010 0000 0000 25b5 0000
ihit_8010       0 8010 0000 0000 25b5 0000
drd_0040        1 0000 0040 0000 0000 a5e5
drd_0041        1 0000 0041 0000 0000 a5e4
drd_0042        1 0000 0042 0000 0000 a5e7
drd_0043        1 0000 0043 0000 0000 a5e6
dwr_miss_0105   2 0000 0105 1234 0000 0000
drd_0105        1 0000 0105 0000 0000 1234
dwr_hit_0106    2 0000 0106 beef 0000 0000
drd_0106        1 0000 0106 0000 0000 beef
drd_0107        1 0000 0107 0000 0000 a4a2
dwr_0208        2 0000 0208 cafe 0000 0000
drd_evict_0308  1 0000 0308 0000 0000 a6ad
drd_back_0208   1 0000 0208 0000 0000 cafe
drd_0209        1 0000 0209 0000 0000 a7ac
drd_evict_0505  1 0000 0505 0000 0000 a0a0
drd_back_0105   1 0000 0105 0000 0000 1234
drd_back_0106   1 0000 0106 0000 0000 beef
both_miss_0120  3 8120 0120 0000 2485 a485
dwr_0444        2 0000 0444 5a5a 0000 0000
both_dirty_0544 3 8444 0544 0000 21e1 a0e1
both_hit_0444   3 8444 0444 0000 21e1 5a5a

/* project.f */
verilog/mem_addr_pkg.sv
verilog/cache_line_pkg.sv
verilog/cache.sv
verilog/unified_mem.sv
verilog/cache_controller.sv
verilog/memory_hierarchy.sv
tb/tb_memory_hierarchy.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_memory_hierarchy
RTL_TOP   = memory_hierarchy
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; st=$$?; cat $(LOG); exit $$st
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/tb_memory_hierarchy.sv */
module tb_memory_hierarchy;
	import cache_line_pkg::*;

	localparam int MEM_LATENCY  = 4;
	localparam int RESET_CYCLES = 10;
	localparam int RAND_COUNT   = 200;
	localparam int NAME_W       = 8 * 24;

	logic              clk;
	logic              i_arst_n;
	logic              i_i_acc;
	logic              i_d_rd_acc;
	logic              i_d_wr_acc;
	logic [15:0]       i_i_addr;
	logic [15:0]       i_d_addr;
	logic [WORD_W-1:0] i_d_wrt_data;
	logic              o_stall;
	logic [WORD_W-1:0] o_instr;
	logic [WORD_W-1:0] o_data;

	logic [WORD_W-1:0] ref_mem [65536];  // word view of the whole hierarchy
	logic [NAME_W-1:0] t_name [$];
	int                t_op [$];
	logic [15:0]       t_ia [$];
	logic [15:0]       t_da [$];
	logic [15:0]       t_wd [$];
	logic [15:0]       t_ei [$];
	logic [15:0]       t_ed [$];
	int                errors;
	int                tests;
	int                failed;
	int                watch_cycles;
	ctrl_state_e       stuck_state;

	memory_hierarchy #(.MEM_LATENCY(MEM_LATENCY)) dut0 (
		.clk(clk), .i_arst_n(i_arst_n), .i_i_acc(i_i_acc), .i_d_rd_acc(i_d_rd_acc),
		.i_d_wr_acc(i_d_wr_acc), .i_i_addr(i_i_addr), .i_d_addr(i_d_addr),
		.i_d_wrt_data(i_d_wrt_data), .o_stall(o_stall), .o_instr(o_instr), .o_data(o_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic load_vectors();
		int                fd;
		int                n;
		logic [8*128-1:0]  line_buf;
		logic [NAME_W-1:0] f_name;
		int                f_op;
		logic [15:0]       f_ia;
		logic [15:0]       f_da;
		logic [15:0]       f_wd;
		logic [15:0]       f_ei;
		logic [15:0]       f_ed;
		fd = $fopen("tb/hier_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open tb/hier_input.txt, no directed tests were run");
			errors++;
			return;
		end
		line_buf = '0;
		while ($fgets(line_buf, fd) > 0) begin
			n = $sscanf(line_buf, "%s %d %h %h %h %h %h", f_name, f_op, f_ia, f_da, f_wd, f_ei, f_ed);
			if (n == 7) begin  // comment and blank lines fall through
				t_name.push_back(f_name);
				t_op.push_back(f_op);
				t_ia.push_back(f_ia);
				t_da.push_back(f_da);
				t_wd.push_back(f_wd);
				t_ei.push_back(f_ei);
				t_ed.push_back(f_ed);
			end
			line_buf = '0;
		end
		$fclose(fd);
	endtask

	// present one access at posedge+1, wait out the stall, sample before the completing edge
	task automatic run_access(input logic ia_en, input logic rd_en, input logic wr_en,
			input logic [15:0] ia, input logic [15:0] da, input logic [15:0] wd,
			output logic [15:0] got_i, output logic [15:0] got_d);
		i_i_acc      = ia_en;
		i_d_rd_acc   = rd_en;
		i_d_wr_acc   = wr_en;
		i_i_addr     = ia;
		i_d_addr     = da;
		i_d_wrt_data = wd;
		@(negedge clk);
		while (o_stall)
			@(negedge clk);
		got_i = o_instr;
		got_d = o_data;
		@(posedge clk);
		#1;
		if (wr_en)
			ref_mem[da] = wd;  // write lands on the completing edge
		i_i_acc    = 1'b0;
		i_d_rd_acc = 1'b0;
		i_d_wr_acc = 1'b0;
	endtask

	task automatic check_word(input logic [NAME_W-1:0] name, input logic [15:0] exp_v,
			input logic [15:0] got_v);
		assert (got_v === exp_v) else begin
			$display("error %0s expected %h actual %h", name, exp_v, got_v);
			errors++;
		end
	endtask

	task automatic report_test(input logic [NAME_W-1:0] name, input int err_before);
		tests++;
		if (errors == err_before) begin
			$display("test %0s ok", name);
		end else begin
			failed++;
			$display("test %0s failed", name);
		end
	endtask

	initial begin
		int          err_before;
		logic [15:0] got_i;
		logic [15:0] got_d;
		logic [15:0] ia;
		logic [15:0] da;
		logic        ri;
		int          rd;
		i_arst_n     = 1'b0;
		i_i_acc      = 1'b0;
		i_d_rd_acc   = 1'b0;
		i_d_wr_acc   = 1'b0;
		i_i_addr     = '0;
		i_d_addr     = '0;
		i_d_wrt_data = '0;
		errors       = 0;
		tests        = 0;
		failed       = 0;
		watch_cycles = 0;
		void'($urandom(40750));
		for (int a = 0; a < 65536; a++)
			ref_mem[a] = 16'(a) ^ 16'hA5A5;  // power-up memory rule
		load_vectors();
		watch_cycles = (t_name.size() + RAND_COUNT) * (2 * MEM_LATENCY + 10) + 2 * RESET_CYCLES;

		err_before = errors;
		repeat (RESET_CYCLES - 1) @(posedge clk);
		@(negedge clk);
		assert (!o_stall) else begin
			$display("o_stall is high while reset is asserted");
			errors++;
		end
		@(posedge clk);
		#1 i_arst_n = 1'b1;
		@(negedge clk);
		assert (!o_stall) else begin
			$display("o_stall is high right after reset with no access pending");
			errors++;
		end
		report_test("reset_stall", err_before);
		@(posedge clk);
		#1;

		foreach (t_name[k]) begin
			err_before = errors;
			if (t_op[k] < 0 || t_op[k] > 3) begin
				$display("test %0s has an unknown operation %0d", t_name[k], t_op[k]);
				errors++;
			end else begin
				run_access(t_op[k] == 0 || t_op[k] == 3, t_op[k] == 1 || t_op[k] == 3,
					t_op[k] == 2, t_ia[k], t_da[k], t_wd[k], got_i, got_d);
				if (t_op[k] == 0 || t_op[k] == 3)
					check_word(t_name[k], t_ei[k], got_i);
				if (t_op[k] == 1 || t_op[k] == 3)
					check_word(t_name[k], t_ed[k], got_d);
			end
			report_test(t_name[k], err_before);
		end

		// few tags over few indices, so misses and write-backs are frequent
		err_before = errors;
		for (int r = 0; r < RAND_COUNT; r++) begin
			ri = 1'($urandom_range(0, 1));
			rd = int'($urandom_range(0, 2));  // 0 none, 1 read, 2 write
			if (!ri && rd == 0)
				rd = 1;
			ia = {8'h80 | 8'($urandom_range(0, 3)), 6'($urandom_range(0, 3)),
				2'($urandom_range(0, 3))};  // never written, upper half
			da = {8'($urandom_range(0, 3)), 6'($urandom_range(0, 3)), 2'($urandom_range(0, 3))};
			run_access(ri, rd == 1, rd == 2, ia, da, 16'($urandom), got_i, got_d);
			if (ri)
				check_word("random_mix", ref_mem[ia], got_i);
			if (rd == 1)
				check_word("random_mix", ref_mem[da], got_d);
		end
		report_test("random_mix", err_before);

		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			tests, tests - failed, failed, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	initial begin
		wait (watch_cycles > 0);
		repeat (watch_cycles) @(posedge clk);
		stuck_state = dut0.ctrl0.state;
		$display("DUT stalled forever, the run did not end within %0d cycles, controller in %s",
			watch_cycles, stuck_state.name());
		$display(">>> FAIL");
		$finish;
	end

endmodule

/* verilog/memory_hierarchy.sv */
module memory_hierarchy #(
	parameter int MEM_LATENCY = 4
) (
	input  logic                              clk,
	input  logic                              i_arst_n,
	input  logic                              i_i_acc,
	input  logic                              i_d_rd_acc,
	input  logic                              i_d_wr_acc,
	input  logic [mem_addr_pkg::ADDR_W-1:0]   i_i_addr,
	input  logic [mem_addr_pkg::ADDR_W-1:0]   i_d_addr,
	input  logic [cache_line_pkg::WORD_W-1:0] i_d_wrt_data,
	output logic                              o_stall,
	output logic [cache_line_pkg::WORD_W-1:0] o_instr,
	output logic [cache_line_pkg::WORD_W-1:0] o_data
);
	import mem_addr_pkg::*;
	import cache_line_pkg::*;

	logic                              d_acc;
	logic                              i_hit;
	logic                              d_hit;
	logic                              d_dirty;
	logic [TAG_W-1:0]                  d_tag;
	cache_line_u                       d_line;
	logic                              i_we;
	logic                              d_we;
	logic                              d_wr_dirty;
	cache_line_u                       i_wr_line;
	cache_line_u                       d_wr_line;
	logic                              wb_cyc;
	logic                              wb_stb;
	logic                              wb_we;
	logic                              wb_ack;
	line_addr_t                        wb_adr;
	logic [WORD_W*WORDS_PER_LINE-1:0]  wb_dat_w;  // master to slave
	logic [WORD_W*WORDS_PER_LINE-1:0]  wb_dat_r;  // slave to master

	assign d_acc = i_d_rd_acc | i_d_wr_acc;

	cache icache0 (
		.clk        (clk),
		.i_arst_n   (i_arst_n),
		.i_addr     (i_i_addr),
		.i_we       (i_we),
		.i_wr_line  (i_wr_line),
		.i_wr_dirty (1'b0),       // instruction lines stay clean
		.o_hit      (i_hit),
		.o_dirty    (),
		.o_tag      (),
		.o_line     (),
		.o_word     (o_instr)
	);

	cache dcache0 (
		.clk        (clk),
		.i_arst_n   (i_arst_n),
		.i_addr     (i_d_addr),
		.i_we       (d_we),
		.i_wr_line  (d_wr_line),
		.i_wr_dirty (d_wr_dirty),
		.o_hit      (d_hit),
		.o_dirty    (d_dirty),
		.o_tag      (d_tag),
		.o_line     (d_line),
		.o_word     (o_data)
	);

	cache_controller ctrl0 (
		.clk          (clk),
		.i_arst_n     (i_arst_n),
		.i_i_acc      (i_i_acc),
		.i_d_acc      (d_acc),
		.i_d_write    (i_d_wr_acc),
		.i_i_addr     (i_i_addr),
		.i_d_addr     (i_d_addr),
		.i_wr_data    (i_d_wrt_data),
		.i_i_hit      (i_hit),
		.i_d_hit      (d_hit),
		.i_d_dirty    (d_dirty),
		.i_d_tag      (d_tag),
		.i_d_line     (d_line),
		.i_wb_ack     (wb_ack),
		.i_wb_dat     (wb_dat_r),
		.o_i_we       (i_we),
		.o_d_we       (d_we),
		.o_d_wr_dirty (d_wr_dirty),
		.o_i_line     (i_wr_line),
		.o_d_line     (d_wr_line),
		.o_wb_cyc     (wb_cyc),
		.o_wb_stb     (wb_stb),
		.o_wb_we      (wb_we),
		.o_wb_adr     (wb_adr),
		.o_wb_dat     (wb_dat_w),
		.o_stall      (o_stall)
	);

	unified_mem #(
		.MEM_LATENCY (MEM_LATENCY)
	) mem0 (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_wb_cyc (wb_cyc),
		.i_wb_stb (wb_stb),
		.i_wb_we  (wb_we),
		.i_wb_adr (wb_adr),
		.i_wb_dat (wb_dat_w),
		.o_wb_ack (wb_ack),
		.o_wb_dat (wb_dat_r)
	);

endmodule

/* verilog/cache_controller.sv */
module cache_controller (
	input  logic                                  clk,
	input  logic                                  i_arst_n,
	input  logic                                  i_i_acc,
	input  logic                                  i_d_acc,
	input  logic                                  i_d_write,
	input  logic [mem_addr_pkg::ADDR_W-1:0]       i_i_addr,
	input  logic [mem_addr_pkg::ADDR_W-1:0]       i_d_addr,
	input  logic [cache_line_pkg::WORD_W-1:0]     i_wr_data,
	input  logic                                  i_i_hit,
	input  logic                                  i_d_hit,
	input  logic                                  i_d_dirty,
	input  logic [mem_addr_pkg::TAG_W-1:0]        i_d_tag,
	input  cache_line_pkg::cache_line_u           i_d_line,
	input  logic                                  i_wb_ack,
	input  logic [cache_line_pkg::WORD_W*cache_line_pkg::WORDS_PER_LINE-1:0] i_wb_dat,
	output logic                                  o_i_we,
	output logic                                  o_d_we,
	output logic                                  o_d_wr_dirty,
	output cache_line_pkg::cache_line_u           o_i_line,
	output cache_line_pkg::cache_line_u           o_d_line,
	output logic                                  o_wb_cyc,
	output logic                                  o_wb_stb,
	output logic                                  o_wb_we,
	output mem_addr_pkg::line_addr_t              o_wb_adr,
	output logic [cache_line_pkg::WORD_W*cache_line_pkg::WORDS_PER_LINE-1:0] o_wb_dat,
	output logic                                  o_stall
);
	import mem_addr_pkg::*;
	import cache_line_pkg::*;

	ctrl_state_e state;
	logic        wb_req;    // drives cyc and stb together
	logic        wb_we;
	logic        d_miss;
	logic        i_miss;
	logic        wr_hit;
	logic        start_wb;
	cache_line_u fill_line;
	cache_line_u merged;

	assign d_miss = i_d_acc & ~i_d_hit;
	assign i_miss = i_i_acc & ~i_i_hit;

	assign o_stall = (state != idle) | d_miss | i_miss;

	// write hit completes only when nothing stalls
	assign wr_hit = (state == idle) & i_d_acc & i_d_write & i_d_hit & ~o_stall;

	// open a bus cycle once per state, bus idles for a cycle after each ack
	assign start_wb = (state != idle) & ~wb_req;

	always_comb begin
		merged = i_d_line;
		merged.words[i_d_addr[OFFSET_W-1:0]] = i_wr_data;  // overlay the written word
	end

	assign fill_line = i_wb_dat;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state  <= idle;
			wb_req <= 1'b0;
			wb_we  <= 1'b0;
		end else begin
			unique case (state)
				idle: begin
					if (d_miss)
						state <= i_d_dirty ? write_back : fill_data;  // data side first
					else if (i_miss)
						state <= fill_instr;
				end
				write_back: begin
					if (start_wb) begin
						wb_req <= 1'b1;
						wb_we  <= 1'b1;
					end else if (i_wb_ack) begin
						wb_req <= 1'b0;
						wb_we  <= 1'b0;
						state  <= fill_data;  // victim out, now fetch
					end
				end
				fill_data, fill_instr: begin
					if (start_wb) begin
						wb_req <= 1'b1;
					end else if (i_wb_ack) begin
						wb_req <= 1'b0;
						state  <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// bus address and write data
	always_ff @(posedge clk) begin
		if (start_wb) begin
			unique case (state)
				write_back: begin
					o_wb_adr <= {i_d_tag, i_d_addr[OFFSET_W +: INDEX_W]};  // victim line
					o_wb_dat <= i_d_line.flat;
				end
				fill_data:  o_wb_adr <= i_d_addr[ADDR_W-1:OFFSET_W];
				fill_instr: o_wb_adr <= i_i_addr[ADDR_W-1:OFFSET_W];
				default:    o_wb_adr <= o_wb_adr;
			endcase
		end
	end

	assign o_wb_cyc = wb_req;
	assign o_wb_stb = wb_req;
	assign o_wb_we  = wb_we;

	assign o_i_we       = (state == fill_instr) & i_wb_ack;
	assign o_i_line     = fill_line;
	assign o_d_we       = ((state == fill_data) & i_wb_ack) | wr_hit;
	assign o_d_wr_dirty = wr_hit;  // fills are clean
	assign o_d_line     = wr_hit ? merged : fill_line;

endmodule

/* verilog/unified_mem.sv */
module unified_mem #(
	parameter int MEM_LATENCY = 4
) (
	input  logic                                                     clk,
	input  logic                                                     i_arst_n,
	input  logic                                                     i_wb_cyc,
	input  logic                                                     i_wb_stb,
	input  logic                                                     i_wb_we,
	input  mem_addr_pkg::line_addr_t                                 i_wb_adr,
	input  logic [cache_line_pkg::WORD_W*cache_line_pkg::WORDS_PER_LINE-1:0] i_wb_dat,
	output logic                                                     o_wb_ack,
	output logic [cache_line_pkg::WORD_W*cache_line_pkg::WORDS_PER_LINE-1:0] o_wb_dat
);
	import mem_addr_pkg::*;
	import cache_line_pkg::*;

	localparam int LINES = 1 << (TAG_W + INDEX_W);
	localparam int CNT_W = $clog2(MEM_LATENCY + 1);

	cache_line_u      mem [LINES];
	cache_line_u      rd_line;
	logic             busy;
	logic [CNT_W-1:0] cnt;
	logic             start;
	logic             fire;

	// defined contents, word at address a holds a ^ A5A5
	initial begin
		for (int l = 0; l < LINES; l++) begin
			for (int w = 0; w < WORDS_PER_LINE; w++) begin
				mem[l].words[w] = ADDR_W'(l * WORDS_PER_LINE + w) ^ 16'hA5A5;
			end
		end
	end

	assign start = i_wb_cyc & i_wb_stb & ~busy & ~o_wb_ack;  // new request only
	assign fire  = (start & (MEM_LATENCY == 1)) | (busy & (cnt == '0));

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			busy     <= 1'b0;
			cnt      <= '0;
			o_wb_ack <= 1'b0;
		end else begin
			o_wb_ack <= fire;  // single-cycle pulse
			if (busy) begin
				if (cnt == '0)
					busy <= 1'b0;
				else
					cnt <= cnt - 1'b1;
			end else if (start && MEM_LATENCY > 1) begin
				busy <= 1'b1;
				cnt  <= CNT_W'(MEM_LATENCY - 2);
			end
		end
	end

	// access happens on the edge that raises ack
	always_ff @(posedge clk) begin
		if (fire) begin
			if (i_wb_we)
				mem[i_wb_adr] <= i_wb_dat;
			rd_line <= mem[i_wb_adr];
		end
	end

	assign o_wb_dat = rd_line.flat;

endmodule

/* verilog/cache.sv */
module cache (
	input  logic                              clk,
	input  logic                              i_arst_n,
	input  logic [mem_addr_pkg::ADDR_W-1:0]   i_addr,
	input  logic                              i_we,
	input  cache_line_pkg::cache_line_u       i_wr_line,
	input  logic                              i_wr_dirty,
	output logic                              o_hit,
	output logic                              o_dirty,
	output logic [mem_addr_pkg::TAG_W-1:0]    o_tag,
	output cache_line_pkg::cache_line_u       o_line,
	output logic [cache_line_pkg::WORD_W-1:0] o_word
);
	import mem_addr_pkg::*;
	import cache_line_pkg::*;

	localparam int LINES = 1 << INDEX_W;

	logic [TAG_W-1:0]    tag;
	logic [INDEX_W-1:0]  index;
	logic [OFFSET_W-1:0] offset;

	logic [LINES-1:0]    valid;
	logic [LINES-1:0]    dirty;
	logic [TAG_W-1:0]    tag_mem [LINES];
	cache_line_u         data_mem [LINES];

	assign tag    = i_addr[ADDR_W-1 -: TAG_W];
	assign index  = i_addr[OFFSET_W +: INDEX_W];
	assign offset = i_addr[OFFSET_W-1:0];

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			valid <= '0;  // all lines empty
		end else if (i_we) begin
			valid[index] <= 1'b1;
		end
	end

	// line payload, tag and dirty flag
	always_ff @(posedge clk) begin
		if (i_we) begin
			data_mem[index] <= i_wr_line;
			tag_mem[index]  <= tag;
			dirty[index]    <= i_wr_dirty;
		end
	end

	assign o_hit   = valid[index] & (tag_mem[index] == tag);
	assign o_dirty = valid[index] & dirty[index];  // an empty line is never a victim
	assign o_tag   = tag_mem[index];  // victim tag for write-back
	assign o_line  = data_mem[index];
	assign o_word  = o_line.words[offset];

endmodule

/* verilog/cache_line_pkg.sv */
package cache_line_pkg;

	localparam int WORD_W         = 16;
	localparam int WORDS_PER_LINE = 4;

	// one 64-bit line, flat for storage and the bus, as words for select and merge
	typedef union packed {
		logic [WORD_W*WORDS_PER_LINE-1:0]      flat;
		logic [WORDS_PER_LINE-1:0][WORD_W-1:0] words;  // word 0 in low bits
	} cache_line_u;

	// controller FSM
	typedef enum logic [1:0] {
		idle       = 2'd0,
		write_back = 2'd1,
		fill_data  = 2'd2,
		fill_instr = 2'd3
	} ctrl_state_e;

endpackage

/* verilog/mem_addr_pkg.sv */
package mem_addr_pkg;

	// word address split: tag | index | offset
	localparam int ADDR_W   = 16;
	localparam int TAG_W    = 8;
	localparam int INDEX_W  = 6;
	localparam int OFFSET_W = 2;

	// whole-line address on the memory bus, tag followed by index
	typedef logic [TAG_W+INDEX_W-1:0] line_addr_t;

endpackage
